/* Bender.yml */
package:
  name: pmci_csr

sources:
  - logic/pmci_csr_pkg.sv
  - logic/time_pulse_gen.sv
  - logic/time_stamp_cntr.sv
  - logic/nios_hb_monitor.sv
  - logic/host_csr_regs.sv
  - logic/nios_csr_regs.sv
  - logic/pmci_csr_top.sv
  - target: test
    files:
      - tb/pmci_csr_assert.sv
      - tb/tb_pmci_csr.sv

/* logic/host_csr_regs.sv */
// Host side register port, 64-bit words
// Holds the flash burst master controls and returns feature header, status and version
`timescale 1ns/1ns

module host_csr_regs
   import pmci_csr_pkg::*;
#(
   parameter int FLASH_ADDR_WIDTH = 28,
   parameter int FIFO_CNT_WIDTH   = 10
)(
   input  logic                        clk,
   input  logic                        reset,
   input  host_addr_t                  host_addr,
   input  logic                        host_write,
   input  logic                        host_read,
   input  host_data_t                  host_wrdata,
   input  logic [7:0]                  host_byteen,
   output host_data_t                  host_rddata,
   output logic                        host_rddvld,
   output logic                        read_mode,
   output logic [FIFO_CNT_WIDTH-1:0]   read_count,
   output logic [FLASH_ADDR_WIDTH-1:0] flash_addr,
   input  logic                        flash_busy,
   input  logic [FIFO_CNT_WIDTH-1:0]   fifo_dcount,
   input  logic                        seu_sys_error,
   input  logic                        m10_stuck,
   input  logic                        nios_stuck,
   input  logic [15:0]                 fw_version
);

   host_data_t fbm_word;
   host_data_t error_word;

   // ----------------------------------------
   // Flash control writes
   // ----------------------------------------
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         read_mode  <= 1'b0;
         read_count <= '0;
         flash_addr <= '0;
      end else if (host_write && host_addr == HOST_FBM_CTRL) begin
         // Low dword and high dword are updated independently
         if (host_byteen[3:0] == 4'hF) begin
            read_mode  <= host_wrdata[1];
            read_count <= host_wrdata[16 +: FIFO_CNT_WIDTH];
         end
         if (host_byteen[7:4] == 4'hF)
            flash_addr <= host_wrdata[32 +: FLASH_ADDR_WIDTH];
      end
   end

   always_comb begin
      fbm_word                          = '0;
      fbm_word[1]                       = read_mode;
      fbm_word[2]                       = flash_busy;
      fbm_word[4 +: FIFO_CNT_WIDTH]     = fifo_dcount;
      fbm_word[16 +: FIFO_CNT_WIDTH]    = read_count;
      fbm_word[32 +: FLASH_ADDR_WIDTH]  = flash_addr;

      error_word    = '0;
      error_word[0] = m10_stuck;
      error_word[1] = nios_stuck;
      error_word[2] = seu_sys_error;
   end

   // ----------------------------------------
   // Read path, data one clock after strobe
   // ----------------------------------------
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         host_rddvld <= 1'b0;
         host_rddata <= '0;
      end else begin
         host_rddvld <= host_read;
         if (host_read) begin
            case (host_addr)
               HOST_DFH      : host_rddata <= DFH_WORD;
               HOST_FBM_CTRL : host_rddata <= fbm_word;
               HOST_ERROR    : host_rddata <= error_word;
               HOST_VERSION  : host_rddata <= {32'd0, fw_version, RTL_VERSION};
               default       : host_rddata <= HOST_BAD_ADDR;
            endcase
         end
      end
   end

endmodule

/* logic/nios_csr_regs.sv */
// Management processor register port, 32-bit words
// Firmware version, thermal shutdown request, heartbeat bit and timestamp readback
`timescale 1ns/1ns

module nios_csr_regs
   import pmci_csr_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  nios_addr_t  nios_addr,
   input  logic        nios_write,
   input  logic        nios_read,
   input  nios_data_t  nios_wrdata,
   output nios_data_t  nios_rddata,
   output logic        nios_rddvld,
   input  nios_data_t  time_stamp,
   output logic [15:0] fw_version,
   output logic        therm_shdn,
   output logic        nios_hb
);

   // ----------------------------------------
   // Register writes
   // ----------------------------------------
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         fw_version <= FW_VER_RESET;
         therm_shdn <= 1'b0;
         nios_hb    <= 1'b0;
      end else if (nios_write) begin
         case (nios_addr)
            NIOS_FW_VER : fw_version <= nios_wrdata[31:16];
            NIOS_THERM  : therm_shdn <= nios_wrdata[0];
            NIOS_HB     : nios_hb    <= nios_wrdata[0];
            default     : ;
         endcase
      end
   end

   // ----------------------------------------
   // Read path
   // ----------------------------------------
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         nios_rddvld <= 1'b0;
         nios_rddata <= '0;
      end else begin
         nios_rddvld <= nios_read;
         if (nios_read) begin
            case (nios_addr)
               NIOS_FW_VER : nios_rddata <= {fw_version, RTL_VERSION};
               NIOS_THERM  : nios_rddata <= {31'd0, therm_shdn};
               NIOS_HB     : nios_rddata <= {31'd0, nios_hb};
               NIOS_TSTAMP : nios_rddata <= time_stamp;
               // Unmapped addresses read as zero
               default     : nios_rddata <= '0;
            endcase
         end
      end
   end

endmodule

/* logic/nios_hb_monitor.sv */
// Heartbeat watchdog, flags stuck after 2^TO_BIT ticks with no heartbeat change
// Set SYNC_STAGES to 2 for an asynchronous pin, 0 for an internal register bit
`timescale 1ns/1ns

module nios_hb_monitor #(
   parameter int TO_BIT      = 9,
   parameter int SYNC_STAGES = 2
)(
   input  logic clk,
   input  logic reset,
   input  logic hb,
   input  logic pulse_tick,
   output logic stuck
);

   logic            hb_s;
   logic            hb_d;
   logic [TO_BIT:0] timer;

   // ----------------------------------------
   // Optional input synchronizer
   // ----------------------------------------
   generate
      if (SYNC_STAGES > 0) begin : g_sync
         logic [SYNC_STAGES-1:0] sync_q;

         always_ff @(posedge clk, posedge reset) begin
            if (reset) begin
               sync_q <= '0;
            end else begin
               sync_q[0] <= hb;
               for (int i = 1; i < SYNC_STAGES; i++)
                  sync_q[i] <= sync_q[i-1];
            end
         end

         assign hb_s = sync_q[SYNC_STAGES-1];
      end else begin : g_nosync
         assign hb_s = hb;
      end
   endgenerate

   // ----------------------------------------
   // Change detect and timeout
   // ----------------------------------------
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         hb_d  <= 1'b0;
         timer <= '0;
      end else begin
         hb_d <= hb_s;
         // Any toggle restarts the timeout, counting stops at the top bit
         if (hb_d != hb_s)
            timer <= '0;
         else if (pulse_tick && !timer[TO_BIT])
            timer <= timer + 1'b1;
      end
   end

   assign stuck = timer[TO_BIT];

endmodule

/* logic/pmci_csr_pkg.sv */
// Shared types, register address maps and constants of the management CSR block
// Imported by wildcard into the register, timestamp and top level modules
package pmci_csr_pkg;

   // Port words
   typedef logic [63:0] host_data_t;
   typedef logic [31:0] nios_data_t;
   typedef logic [4:0]  host_addr_t;
   typedef logic [5:0]  nios_addr_t;

   // Host port register map
   typedef enum host_addr_t {
      HOST_DFH      = 5'd0,
      HOST_FBM_CTRL = 5'd8,
      HOST_ERROR    = 5'd9,
      HOST_VERSION  = 5'd31
   } host_reg_e;

   // Management processor register map
   typedef enum nios_addr_t {
      NIOS_FW_VER = 6'd0,
      NIOS_THERM  = 6'd1,
      NIOS_HB     = 6'd2,
      NIOS_TSTAMP = 6'd16
   } nios_reg_e;

   localparam logic [15:0] RTL_VERSION  = 16'h0021;
   localparam logic [15:0] FW_VER_RESET = 16'hFFFF;

   // Device feature header
   localparam host_data_t DFH_WORD = {4'h3,        // feature type
                                      19'h0,
                                      1'b0,        // end of list
                                      24'h080000,  // next header offset
                                      4'h1,        // feature revision
                                      12'h012};    // feature ID

   localparam host_data_t HOST_BAD_ADDR = 64'hBAADBEEF_DEADBEEF;

   // Each timestamp half
   localparam int TSTAMP_HALF_W = 11;

endpackage

/* logic/pmci_csr_top.sv */
// Top level of the management controller CSR block
// Connects the host and processor register ports, time base, timestamp and watchdogs
`timescale 1ns/1ns

module pmci_csr_top
   import pmci_csr_pkg::*;
#(
   parameter int FLASH_ADDR_WIDTH = 28,
   parameter int FIFO_CNT_WIDTH   = 10,
   parameter int CLKS_PER_US      = 100,
   parameter int US_PER_TICK      = 4000,
   parameter int M10_HB_TO_BIT    = 9,
   parameter int NIOS_HB_TO_BIT   = 8
)(
   input  logic                        clk,
   input  logic                        reset,

   // Host register port
   input  host_addr_t                  host_addr,
   input  logic                        host_write,
   input  logic                        host_read,
   input  host_data_t                  host_wrdata,
   input  logic [7:0]                  host_byteen,
   output host_data_t                  host_rddata,
   output logic                        host_rddvld,

   // Management processor port
   input  nios_addr_t                  nios_addr,
   input  logic                        nios_write,
   input  logic                        nios_read,
   input  nios_data_t                  nios_wrdata,
   output nios_data_t                  nios_rddata,
   output logic                        nios_rddvld,

   // Flash burst master
   output logic                        read_mode,
   output logic [FIFO_CNT_WIDTH-1:0]   read_count,
   output logic [FLASH_ADDR_WIDTH-1:0] flash_addr,
   input  logic                        flash_busy,
   input  logic [FIFO_CNT_WIDTH-1:0]   fifo_dcount,

   // Board level signals
   input  logic                        seu_sys_error,
   input  logic                        m10_hb,
   output logic                        therm_shdn,
   output logic                        pulse_us
);

   logic       pulse_tick;
   nios_data_t time_stamp;
   logic [15:0] fw_version;
   logic       nios_hb;
   logic       m10_stuck;
   logic       nios_stuck;

   // ----------------------------------------
   // Time base
   // ----------------------------------------
   time_pulse_gen #(
      .CLKS_PER_US (CLKS_PER_US),
      .US_PER_TICK (US_PER_TICK)
   ) u_pulse_gen (
      .clk        (clk),
      .reset      (reset),
      .pulse_us   (pulse_us),
      .pulse_tick (pulse_tick)
   );

   time_stamp_cntr u_tstamp (
      .clk        (clk),
      .reset      (reset),
      .pulse_tick (pulse_tick),
      .time_stamp (time_stamp)
   );

   // ----------------------------------------
   // Heartbeat watchdogs
   // ----------------------------------------
   // Board controller pin is asynchronous
   nios_hb_monitor #(
      .TO_BIT      (M10_HB_TO_BIT),
      .SYNC_STAGES (2)
   ) u_m10_hb_mon (
      .clk        (clk),
      .reset      (reset),
      .hb         (m10_hb),
      .pulse_tick (pulse_tick),
      .stuck      (m10_stuck)
   );

   nios_hb_monitor #(
      .TO_BIT      (NIOS_HB_TO_BIT),
      .SYNC_STAGES (0)
   ) u_nios_hb_mon (
      .clk        (clk),
      .reset      (reset),
      .hb         (nios_hb),
      .pulse_tick (pulse_tick),
      .stuck      (nios_stuck)
   );

   // ----------------------------------------
   // Register ports
   // ----------------------------------------
   host_csr_regs #(
      .FLASH_ADDR_WIDTH (FLASH_ADDR_WIDTH),
      .FIFO_CNT_WIDTH   (FIFO_CNT_WIDTH)
   ) u_host_regs (
      .clk           (clk),
      .reset         (reset),
      .host_addr     (host_addr),
      .host_write    (host_write),
      .host_read     (host_read),
      .host_wrdata   (host_wrdata),
      .host_byteen   (host_byteen),
      .host_rddata   (host_rddata),
      .host_rddvld   (host_rddvld),
      .read_mode     (read_mode),
      .read_count    (read_count),
      .flash_addr    (flash_addr),
      .flash_busy    (flash_busy),
      .fifo_dcount   (fifo_dcount),
      .seu_sys_error (seu_sys_error),
      .m10_stuck     (m10_stuck),
      .nios_stuck    (nios_stuck),
      .fw_version    (fw_version)
   );

   nios_csr_regs u_nios_regs (
      .clk         (clk),
      .reset       (reset),
      .nios_addr   (nios_addr),
      .nios_write  (nios_write),
      .nios_read   (nios_read),
      .nios_wrdata (nios_wrdata),
      .nios_rddata (nios_rddata),
      .nios_rddvld (nios_rddvld),
      .time_stamp  (time_stamp),
      .fw_version  (fw_version),
      .therm_shdn  (therm_shdn),
      .nios_hb     (nios_hb)
   );

endmodule

/* logic/time_pulse_gen.sv */
// Microsecond and tick pulse generator
// pulse_us every CLKS_PER_US clocks, pulse_tick one clock after every US_PER_TICK-th pulse_us
`timescale 1ns/1ns

module time_pulse_gen #(
   parameter int CLKS_PER_US = 100,
   parameter int US_PER_TICK = 4000
)(
   input  logic clk,
   input  logic reset,
   output logic pulse_us,
   output logic pulse_tick
);

   localparam int CLK_CNT_W = $clog2(CLKS_PER_US + 1);
   localparam int US_CNT_W  = $clog2(US_PER_TICK + 1);

   logic [CLK_CNT_W-1:0] clk_cnt;
   logic [US_CNT_W-1:0]  us_cnt;

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         clk_cnt    <= '0;
         us_cnt     <= '0;
         pulse_us   <= 1'b0;
         pulse_tick <= 1'b0;
      end else begin
         // Clock counter wraps once per microsecond
         if (clk_cnt == CLK_CNT_W'(CLKS_PER_US - 1))
            clk_cnt <= '0;
         else
            clk_cnt <= clk_cnt + 1'b1;
         pulse_us <= (clk_cnt == CLK_CNT_W'(CLKS_PER_US - 1));

         // Count microsecond pulses toward the next tick
         if (pulse_us) begin
            if (us_cnt == US_CNT_W'(US_PER_TICK - 1))
               us_cnt <= '0;
            else
               us_cnt <= us_cnt + 1'b1;
         end
         pulse_tick <= pulse_us && (us_cnt == US_CNT_W'(US_PER_TICK - 1));
      end
   end

endmodule

/* logic/time_stamp_cntr.sv */
// Free-running timestamp in tick units, split in two halves with a sticky wrap flag
// Output is laid out as the processor timestamp register word
`timescale 1ns/1ns

module time_stamp_cntr
   import pmci_csr_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       pulse_tick,
   output nios_data_t time_stamp
);

   logic [TSTAMP_HALF_W-1:0] ts_lower;
   logic [TSTAMP_HALF_W-1:0] ts_upper;
   logic                     ts_lower_max;
   logic                     ts_wrap;

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         ts_lower     <= '0;
         ts_upper     <= '0;
         ts_lower_max <= 1'b0;
         ts_wrap      <= 1'b0;
      end else begin
         if (pulse_tick)
            ts_lower <= ts_lower + 1'b1;

         // Carry into the upper half, one clock late
         ts_lower_max <= (ts_lower == '1);
         if (pulse_tick && ts_lower_max)
            ts_upper <= ts_upper + 1'b1;

         // Once set the timestamp is no longer absolute
         if (ts_upper == '1)
            ts_wrap <= 1'b1;
      end
   end

   assign time_stamp = {ts_wrap,
                        {(32 - 3 - 2 * TSTAMP_HALF_W){1'b0}},
                        ts_upper,
                        ts_lower,
                        2'b00};

endmodule

/* pmci_csr_top.f */
logic/pmci_csr_pkg.sv
logic/time_pulse_gen.sv
logic/time_stamp_cntr.sv
logic/nios_hb_monitor.sv
logic/host_csr_regs.sv
logic/nios_csr_regs.sv
logic/pmci_csr_top.sv
tb/pmci_csr_assert.sv
tb/tb_pmci_csr.sv

/* tb/pmci_csr_assert.sv */
// Protocol and pulse shape assertions for the management CSR block
// Attached to pmci_csr_top by the bind at the end of this file
`timescale 1ns/1ns

module pmci_csr_assert (
   input logic clk,
   input logic reset,
   input logic host_read,
   input logic host_rddvld,
   input logic nios_read,
   input logic nios_rddvld,
   input logic pulse_us,
   input logic therm_shdn
);

   // Number of failed assertions
   int fail_count = 0;

   // Read data valid exactly one clock after each strobe
   host_read_valid: assert property (@(posedge clk) disable iff (reset)
      host_read |=> host_rddvld)
      else begin
         $error("host read strobe without valid one clock later");
         fail_count++;
      end

   nios_read_valid: assert property (@(posedge clk) disable iff (reset)
      nios_read |=> nios_rddvld)
      else begin
         $error("nios read strobe without valid one clock later");
         fail_count++;
      end

   // Microsecond pulse is a single clock wide
   pulse_us_single: assert property (@(posedge clk) disable iff (reset)
      pulse_us |=> !pulse_us)
      else begin
         $error("pulse_us high on two consecutive cycles");
         fail_count++;
      end

   therm_after_reset: assert property (@(posedge clk)
      $fell(reset) |-> !therm_shdn)
      else begin
         $error("therm_shdn high after reset");
         fail_count++;
      end

endmodule

bind pmci_csr_top pmci_csr_assert u_csr_assert (
   .clk         (clk),
   .reset       (reset),
   .host_read   (host_read),
   .host_rddvld (host_rddvld),
   .nios_read   (nios_read),
   .nios_rddvld (nios_rddvld),
   .pulse_us    (pulse_us),
   .therm_shdn  (therm_shdn)
);

/* tb/tb_pmci_csr.sv */
// Directed testbench for the management controller CSR block
// Runs each test task in turn against pmci_csr_top and stops at the first mismatch
`timescale 1ns/1ns

module tb_pmci_csr
   import pmci_csr_pkg::*;
;

   localparam int FLASH_ADDR_WIDTH = 28;
   localparam int FIFO_CNT_WIDTH   = 10;
   localparam int CLKS_PER_US      = 10;
   localparam int US_PER_TICK      = 4;
   localparam int READ_TIMEOUT     = 8;

   // Feature header built from its fields
   localparam host_data_t EXP_DFH = (64'h3 << 60) | (64'h0 << 40) | (64'h80000 << 16) |
                                    (64'h1 << 12) | 64'h012;

   logic                        clk;
   logic                        reset;
   host_addr_t                  host_addr;
   logic                        host_wr_stb;
   logic                        host_rd_stb;
   host_data_t                  host_wrdata;
   logic [7:0]                  host_byteen;
   host_data_t                  host_rddata;
   logic                        host_rddvld;
   nios_addr_t                  nios_addr;
   logic                        nios_wr_stb;
   logic                        nios_rd_stb;
   nios_data_t                  nios_wrdata;
   nios_data_t                  nios_rddata;
   logic                        nios_rddvld;
   logic                        read_mode;
   logic [FIFO_CNT_WIDTH-1:0]   read_count;
   logic [FLASH_ADDR_WIDTH-1:0] flash_addr;
   logic                        flash_busy;
   logic [FIFO_CNT_WIDTH-1:0]   fifo_dcount;
   logic                        seu_sys_error;
   logic                        m10_hb;
   logic                        therm_shdn;
   logic                        pulse_us;

   logic [15:0] lfsr_state;
   logic        hb_bit;
   string       test_name;

   pmci_csr_top #(
      .FLASH_ADDR_WIDTH (FLASH_ADDR_WIDTH),
      .FIFO_CNT_WIDTH   (FIFO_CNT_WIDTH),
      .CLKS_PER_US      (CLKS_PER_US),
      .US_PER_TICK      (US_PER_TICK),
      .M10_HB_TO_BIT    (3),
      .NIOS_HB_TO_BIT   (2)
   ) DUT (
      .clk           (clk),
      .reset         (reset),
      .host_addr     (host_addr),
      .host_write    (host_wr_stb),
      .host_read     (host_rd_stb),
      .host_wrdata   (host_wrdata),
      .host_byteen   (host_byteen),
      .host_rddata   (host_rddata),
      .host_rddvld   (host_rddvld),
      .nios_addr     (nios_addr),
      .nios_write    (nios_wr_stb),
      .nios_read     (nios_rd_stb),
      .nios_wrdata   (nios_wrdata),
      .nios_rddata   (nios_rddata),
      .nios_rddvld   (nios_rddvld),
      .read_mode     (read_mode),
      .read_count    (read_count),
      .flash_addr    (flash_addr),
      .flash_busy    (flash_busy),
      .fifo_dcount   (fifo_dcount),
      .seu_sys_error (seu_sys_error),
      .m10_hb        (m10_hb),
      .therm_shdn    (therm_shdn),
      .pulse_us      (pulse_us)
   );

   always #5 clk = ~clk;

   // ----------------------------------------
   // Random bits and result checks
   // ----------------------------------------
   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_random(input int nbits, output host_data_t value);
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value      = {value[62:0], lfsr_state[0]};
      end
   endtask

   task automatic fail_now(input string reason);
      $display("%s in test %s", reason, test_name);
      $display("Test failures found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_host(input string what, input host_data_t expected,
                             input host_data_t actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s %s: expected %h actual %h",
                  test_name, what, expected, actual);
         fail_now("host value mismatch");
      end
   endtask

   task automatic check_nios(input string what, input nios_data_t expected,
                             input nios_data_t actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s %s: expected %h actual %h",
                  test_name, what, expected, actual);
         fail_now("nios value mismatch");
      end
   endtask

   // ----------------------------------------
   // Port access
   // ----------------------------------------
   task automatic host_write(input host_addr_t addr, input host_data_t data,
                             input logic [7:0] be);
      @(negedge clk);
      host_addr   = addr;
      host_wrdata = data;
      host_byteen = be;
      host_wr_stb = 1'b1;
      @(negedge clk);
      host_wr_stb = 1'b0;
   endtask

   task automatic host_read(input host_addr_t addr, output host_data_t data);
      int cycles;
      @(negedge clk);
      host_addr   = addr;
      host_rd_stb = 1'b1;
      @(negedge clk);
      host_rd_stb = 1'b0;
      cycles = 0;
      while (!host_rddvld && cycles < READ_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (!host_rddvld)
         fail_now("host read valid never arrived");
      data = host_rddata;
   endtask

   task automatic nios_write(input nios_addr_t addr, input nios_data_t data);
      @(negedge clk);
      nios_addr   = addr;
      nios_wrdata = data;
      nios_wr_stb = 1'b1;
      @(negedge clk);
      nios_wr_stb = 1'b0;
   endtask

   task automatic nios_read(input nios_addr_t addr, output nios_data_t data);
      int cycles;
      @(negedge clk);
      nios_addr   = addr;
      nios_rd_stb = 1'b1;
      @(negedge clk);
      nios_rd_stb = 1'b0;
      cycles = 0;
      while (!nios_rddvld && cycles < READ_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (!nios_rddvld)
         fail_now("nios read valid never arrived");
      data = nios_rddata;
   endtask

   // Clocks until the next pulse_us
   task automatic wait_pulse_us(output int cycles);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!pulse_us && cycles < 4 * CLKS_PER_US);
      if (!pulse_us)
         fail_now("pulse_us did not arrive in time");
   endtask

   // ----------------------------------------
   // Tests
   // ----------------------------------------
   task automatic test_reset_values();
      host_data_t hd;
      nios_data_t nd;
      test_name = "reset_values";
      host_read(HOST_DFH, hd);
      check_host("feature header", EXP_DFH, hd);
      host_read(HOST_VERSION, hd);
      check_host("version word", {32'd0, 16'hFFFF, 16'h0021}, hd);
      host_read(5'd3, hd);
      check_host("unmapped host address", 64'hBAADBEEF_DEADBEEF, hd);
      nios_read(NIOS_FW_VER, nd);
      check_nios("nios version word", {16'hFFFF, 16'h0021}, nd);
      nios_read(6'd5, nd);
      check_nios("unmapped nios address", 32'd0, nd);
   endtask

   task automatic test_flash_ctrl();
      logic [7:0]                  be_list [3];
      logic                        exp_mode;
      logic [FIFO_CNT_WIDTH-1:0]   exp_count;
      logic [FLASH_ADDR_WIDTH-1:0] exp_addr;
      host_data_t                  data;
      host_data_t                  exp_word;
      host_data_t                  rd;
      test_name = "flash_ctrl";
      be_list   = '{8'hFF, 8'h0F, 8'hF0};
      exp_mode  = 1'b0;
      exp_count = '0;
      exp_addr  = '0;
      foreach (be_list[i]) begin
         take_random(1, data);
         flash_busy = data[0];
         take_random(FIFO_CNT_WIDTH, data);
         fifo_dcount = data[FIFO_CNT_WIDTH-1:0];
         take_random(64, data);
         host_write(HOST_FBM_CTRL, data, be_list[i]);
         if (be_list[i][3:0] == 4'hF) begin
            exp_mode  = data[1];
            exp_count = data[25:16];
         end
         if (be_list[i][7:4] == 4'hF)
            exp_addr = data[32 +: FLASH_ADDR_WIDTH];
         check_host("control outputs", 64'({exp_addr, exp_count, exp_mode}),
                    64'({flash_addr, read_count, read_mode}));
         exp_word = '0;
         exp_word[1]                      = exp_mode;
         exp_word[2]                      = flash_busy;
         exp_word[13:4]                   = fifo_dcount;
         exp_word[25:16]                  = exp_count;
         exp_word[32 +: FLASH_ADDR_WIDTH] = exp_addr;
         host_read(HOST_FBM_CTRL, rd);
         check_host("control readback", exp_word, rd);
      end
   endtask

   task automatic test_nios_regs();
      host_data_t r;
      host_data_t hd;
      nios_data_t nd;
      logic [15:0] fw;
      logic        therm;
      test_name = "nios_regs";
      take_random(16, r);
      fw = r[15:0];
      take_random(1, r);
      therm = r[0];
      take_random(1, r);
      hb_bit = r[0];
      nios_write(NIOS_FW_VER, {fw, 16'h0000});
      nios_write(NIOS_THERM, {31'd0, therm});
      nios_write(NIOS_HB, {31'd0, hb_bit});
      nios_read(NIOS_FW_VER, nd);
      check_nios("firmware version", {fw, 16'h0021}, nd);
      nios_read(NIOS_THERM, nd);
      check_nios("thermal readback", {31'd0, therm}, nd);
      check_nios("thermal output", {31'd0, therm}, {31'd0, therm_shdn});
      nios_read(NIOS_HB, nd);
      check_nios("heartbeat readback", {31'd0, hb_bit}, nd);
      host_read(HOST_VERSION, hd);
      check_host("host version word", {32'd0, fw, 16'h0021}, hd);
   endtask

   task automatic test_pulse_us();
      int cycles;
      test_name = "pulse_us";
      wait_pulse_us(cycles);
      for (int i = 0; i < 5; i++) begin
         wait_pulse_us(cycles);
         check_nios("pulse spacing", CLKS_PER_US, cycles);
      end
   endtask

   task automatic test_timestamp();
      nios_data_t ts1;
      nios_data_t ts2;
      logic [10:0] delta;
      int          cycles;
      test_name = "timestamp";
      nios_read(NIOS_TSTAMP, ts1);
      // One tick every US_PER_TICK microsecond pulses
      for (int i = 0; i < 20 * US_PER_TICK; i++)
         wait_pulse_us(cycles);
      nios_read(NIOS_TSTAMP, ts2);
      delta = ts2[12:2] - ts1[12:2];
      if (delta != 11'd19 && delta != 11'd21)
         check_nios("lower half delta", 32'd20, 32'(delta));
      check_nios("wrap and reserved bits", 32'd0, ts2 & 32'hFF00_0003);
   endtask

   task automatic test_heartbeat();
      host_data_t rd;
      int         tries;
      int         cycles;
      test_name = "heartbeat";
      tries = 0;
      do begin
         host_read(HOST_ERROR, rd);
         wait_pulse_us(cycles);
         tries++;
      end while (rd[1:0] != 2'b11 && tries < 80);
      check_host("both watchdogs stuck", 64'h3, rd);

      // Fresh heartbeats on both sources
      @(negedge clk);
      m10_hb = ~m10_hb;
      hb_bit = ~hb_bit;
      nios_write(NIOS_HB, {31'd0, hb_bit});
      tries = 0;
      do begin
         host_read(HOST_ERROR, rd);
         tries++;
      end while (rd[1:0] != 2'b00 && tries < 4);
      check_host("watchdogs cleared", 64'h0, rd);

      @(negedge clk);
      seu_sys_error = 1'b1;
      host_read(HOST_ERROR, rd);
      check_host("seu error bit", 64'h4, rd);
      seu_sys_error = 1'b0;
   endtask

   // Stop at the first failed protocol assertion
   always @(DUT.u_csr_assert.fail_count) begin
      if (DUT.u_csr_assert.fail_count != 0)
         fail_now("a protocol assertion failed");
   end

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin
      clk           = 1'b0;
      reset         = 1'b1;
      host_addr     = '0;
      host_wr_stb   = 1'b0;
      host_rd_stb   = 1'b0;
      host_wrdata   = '0;
      host_byteen   = '0;
      nios_addr     = '0;
      nios_wr_stb   = 1'b0;
      nios_rd_stb   = 1'b0;
      nios_wrdata   = '0;
      flash_busy    = 1'b0;
      fifo_dcount   = '0;
      seu_sys_error = 1'b0;
      m10_hb        = 1'b0;
      lfsr_state    = 16'd85;
      hb_bit        = 1'b0;
      test_name     = "reset";
      repeat (2) @(negedge clk);
      reset = 1'b0;

      test_reset_values();
      test_flash_ctrl();
      test_nios_regs();
      test_pulse_us();
      test_timestamp();
      test_heartbeat();

      $display("All tests passed!");
      $finish;
   end

endmodule
